// File: bench/rs_checker.sv
module rs_checker (
	input logic clk,
	input logic checking,
	input logic done,
	input logic [2:0] test_id,
	input logic exp_full,
	input logic exp_issue,
	input logic [90:0] exp_ops [16],
	input int n_exp,
	input logic full,
	input logic exec_lock,
	input logic issue_valid,
	input logic [4:0] issue_cmd,
	input logic [3:0] issue_afe,
	input logic issue_sys_reg,
	input logic issue_logic,
	input logic issue_shift,
	input logic issue_adder,
	input logic issue_writeback,
	input logic issue_destination_sysreg,
	input logic [31:0] issue_source0,
	input logic [31:0] issue_source1,
	input logic [5:0] issue_destination_regname,
	input logic [5:0] issue_commit_tag,
	output int fail_count
);
	timeunit 1ns;
	timeprecision 100ps;

	int op_idx = 0;
	int checks = 0;
	int tests = 0;
	int test_errors = 0;
	logic [2:0] cur_test = 3'd0;
	logic prev_valid = 1'b0;
	logic prev_lock = 1'b0;
	logic finished = 1'b0;
	logic [90:0] last_op = '0;

	initial fail_count = 0;

	task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			fail_count++;
			test_errors++;
		end
	endtask

	task compare_op(input logic [90:0] op);
		compare("issue_destination_sysreg", 32'(issue_destination_sysreg), 32'(op[90]));
		compare("issue_writeback", 32'(issue_writeback), 32'(op[89]));
		compare("issue_afe", 32'(issue_afe), 32'(op[88:85]));
		compare("issue_sys_reg", 32'(issue_sys_reg), 32'(op[84]));
		compare("issue_logic", 32'(issue_logic), 32'(op[83]));
		compare("issue_shift", 32'(issue_shift), 32'(op[82]));
		compare("issue_adder", 32'(issue_adder), 32'(op[81]));
		compare("issue_cmd", 32'(issue_cmd), 32'(op[80:76]));
		compare("issue_source0", issue_source0, op[75:44]);
		compare("issue_source1", issue_source1, op[43:12]);
		compare("issue_destination_regname", 32'(issue_destination_regname), 32'(op[11:6]));
		compare("issue_commit_tag", 32'(issue_commit_tag), 32'(op[5:0]));
	endtask

	task close_test();
		$display("test %0d: %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "failed",
			test_errors);
		tests++;
		test_errors = 0;
	endtask

	always @(posedge clk) begin
		if (done && !finished) begin
			if (op_idx != n_exp) begin
				$display("Missing issues: %0d of %0d expected operations never issued",
					n_exp - op_idx, n_exp);
				fail_count++;
				test_errors++;
			end
			close_test();
			$display("tests %0d, checks %0d, errors %0d", tests, checks, fail_count);
			finished = 1'b1;
		end else if (checking && !done) begin
			if (test_id != cur_test) begin
				if (cur_test != 3'd0) close_test();
				cur_test = test_id;
			end
			compare("full", 32'(full), 32'(exp_full));
			compare("issue_valid", 32'(issue_valid), 32'(exp_issue));
			if (issue_valid) begin
				// Held under lock with unchanged data
				if (prev_valid && prev_lock) begin
					compare_op(last_op);
				end else if (op_idx >= n_exp) begin
					$display("Unexpected issue at %0t with tag %0d", $time, issue_commit_tag);
					fail_count++;
					test_errors++;
				end else begin
					last_op = exp_ops[op_idx];
					compare_op(last_op);
					op_idx++;
				end
			end
			prev_valid = issue_valid;
			prev_lock = exec_lock;
		end
	end

endmodule

// File: bench/tb_reservation_alu2.sv
module tb_reservation_alu2;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ROWS = 40;
	localparam int MAX_EXP = 16;

	typedef struct packed {
		logic rv;
		logic [9:0] flags;
		logic [4:0] cmd;
		logic s0v;
		logic [31:0] s0;
		logic s1v;
		logic [31:0] s1;
		logic [5:0] dest;
		logic [5:0] tag;
		logic c0v;
		logic c0wb;
		logic [5:0] c0n;
		logic [31:0] c0d;
		logic c1v;
		logic c1wb;
		logic [5:0] c1n;
		logic [31:0] c1d;
		logic c2v;
		logic [5:0] c2n;
		logic [31:0] c2d;
		logic rm;
		logic lock;
		logic [2:0] test;
		logic exp_full;
		logic exp_issue;
	} row_t;

	logic iCLOCK;
	logic inRESET;
	logic remove_valid;
	logic register_valid;
	logic full;
	logic destination_sysreg;
	logic writeback;
	logic [4:0] cmd;
	logic [3:0] afe;
	logic sys_reg;
	logic logic_op;
	logic shift;
	logic adder;
	logic source0_valid;
	logic [31:0] source0;
	logic source1_valid;
	logic [31:0] source1;
	logic [5:0] destination_regname;
	logic [5:0] commit_tag;
	logic cdb0_valid;
	logic cdb0_writeback;
	logic [5:0] cdb0_regname;
	logic [31:0] cdb0_data;
	logic cdb1_valid;
	logic cdb1_writeback;
	logic [5:0] cdb1_regname;
	logic [31:0] cdb1_data;
	logic cdb2_valid;
	logic [5:0] cdb2_regname;
	logic [31:0] cdb2_data;
	logic exec_lock;
	logic issue_valid;
	logic [4:0] issue_cmd;
	logic [3:0] issue_afe;
	logic issue_sys_reg;
	logic issue_logic;
	logic issue_shift;
	logic issue_adder;
	logic issue_writeback;
	logic issue_destination_sysreg;
	logic [31:0] issue_source0;
	logic [31:0] issue_source1;
	logic [5:0] issue_destination_regname;
	logic [5:0] issue_commit_tag;

	row_t rows [N_ROWS];
	int n_rows;
	logic [90:0] exp_ops [MAX_EXP];
	int n_exp;
	logic [31:0] d [26];
	logic [9:0] fl [16];
	logic checking;
	logic done;
	logic [2:0] test_id;
	logic exp_full;
	logic exp_issue;
	int fail_count;

	reservation_alu2 dut_i (
		.iCLOCK, .inRESET, .remove_valid, .register_valid, .full,
		.destination_sysreg, .writeback, .cmd, .afe,
		.sys_reg, .logic_op, .shift, .adder,
		.source0_valid, .source0, .source1_valid, .source1,
		.destination_regname, .commit_tag,
		.cdb0_valid, .cdb0_writeback, .cdb0_regname, .cdb0_data,
		.cdb1_valid, .cdb1_writeback, .cdb1_regname, .cdb1_data,
		.cdb2_valid, .cdb2_regname, .cdb2_data,
		.exec_lock, .issue_valid, .issue_cmd,
		.issue_afe, .issue_sys_reg, .issue_logic, .issue_shift, .issue_adder,
		.issue_writeback, .issue_destination_sysreg,
		.issue_source0, .issue_source1, .issue_destination_regname, .issue_commit_tag
	);

	rs_checker checker_i (
		.clk(iCLOCK), .checking, .done, .test_id, .exp_full, .exp_issue, .exp_ops, .n_exp,
		.full, .exec_lock, .issue_valid, .issue_cmd,
		.issue_afe, .issue_sys_reg, .issue_logic, .issue_shift, .issue_adder,
		.issue_writeback, .issue_destination_sysreg,
		.issue_source0, .issue_source1,
		.issue_destination_regname, .issue_commit_tag, .fail_count
	);

	function automatic row_t idle_row(input logic [2:0] t);
		row_t r;
		r = '0;
		r.test = t;
		return r;
	endfunction

	function automatic row_t dispatch_row(input logic [2:0] t, input int c,
		input logic v0, input logic [31:0] w0, input logic v1, input logic [31:0] w1,
		input int dst, input int tg);
		row_t r;
		r = idle_row(t);
		r.rv = 1'b1;
		r.flags = fl[c];
		r.cmd = 5'(c);
		r.s0v = v0;
		r.s0 = w0;
		r.s1v = v1;
		r.s1 = w1;
		r.dest = 6'(dst);
		r.tag = 6'(tg);
		return r;
	endfunction

	task automatic add_row(input row_t r);
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic mark_issue(input int k);
		rows[k].exp_issue = 1'b1;
	endtask

	task automatic expect_op(input int c, input logic [31:0] a, input logic [31:0] b,
		input int dst, input int tg);
		exp_ops[n_exp] = {fl[c], 5'(c), a, b, 6'(dst), 6'(tg)};
		n_exp++;
	endtask

	task automatic build_tables();
		row_t r;
		int base;
		// Issue one cycle after dispatch
		base = n_rows;
		add_row(dispatch_row(3'd1, 1, 1'b1, d[0], 1'b1, d[1], 10, 1));
		repeat (3) add_row(idle_row(3'd1));
		mark_issue(base + 2);
		expect_op(1, d[0], d[1], 10, 1);
		// Same-cycle forwarding and channel priority
		base = n_rows;
		r = dispatch_row(3'd2, 2, 1'b0, 32'd5, 1'b0, 32'd6, 11, 2);
		{r.c0v, r.c0wb, r.c0n, r.c0d} = {2'b10, 6'd5, d[2]};
		{r.c1v, r.c1wb, r.c1n, r.c1d} = {2'b11, 6'd5, d[3]};
		{r.c2v, r.c2n, r.c2d} = {1'b1, 6'd6, d[4]};
		add_row(r);
		r = dispatch_row(3'd2, 3, 1'b0, 32'd7, 1'b0, 32'd7, 12, 3);
		{r.c0v, r.c0wb, r.c0n, r.c0d} = {2'b11, 6'd7, d[5]};
		{r.c1v, r.c1wb, r.c1n, r.c1d} = {2'b11, 6'd7, d[6]};
		{r.c2v, r.c2n, r.c2d} = {1'b1, 6'd7, d[7]};
		add_row(r);
		r = dispatch_row(3'd2, 4, 1'b0, 32'd8, 1'b1, d[8], 13, 4);
		{r.c1v, r.c1wb, r.c1n, r.c1d} = {2'b10, 6'd8, d[9]};
		{r.c2v, r.c2n, r.c2d} = {1'b1, 6'd8, d[10]};
		add_row(r);
		repeat (2) add_row(idle_row(3'd2));
		for (int k = 2; k <= 4; k++) mark_issue(base + k);
		expect_op(2, d[3], d[4], 11, 2);
		expect_op(3, d[5], d[5], 12, 3);
		expect_op(4, d[10], d[8], 13, 4);
		// Wakeup from the CDB after dispatch
		base = n_rows;
		add_row(dispatch_row(3'd3, 5, 1'b0, 32'd20, 1'b0, 32'd21, 14, 5));
		r = idle_row(3'd3);
		{r.c0v, r.c0wb, r.c0n, r.c0d} = {2'b11, 6'd20, d[11]};
		add_row(r);
		r = idle_row(3'd3);
		{r.c0v, r.c0wb, r.c0n, r.c0d} = {2'b10, 6'd21, d[12]};
		add_row(r);
		r = idle_row(3'd3);
		{r.c2v, r.c2n, r.c2d} = {1'b1, 6'd21, d[13]};
		add_row(r);
		repeat (3) add_row(idle_row(3'd3));
		mark_issue(base + 5);
		expect_op(5, d[11], d[13], 14, 5);
		// Fill all four entries and wake them with one broadcast
		base = n_rows;
		add_row(dispatch_row(3'd4, 6, 1'b0, 32'd30, 1'b1, d[14], 15, 6));
		add_row(dispatch_row(3'd4, 7, 1'b0, 32'd30, 1'b1, d[15], 16, 7));
		add_row(dispatch_row(3'd4, 8, 1'b1, d[16], 1'b0, 32'd30, 17, 8));
		add_row(dispatch_row(3'd4, 9, 1'b0, 32'd30, 1'b0, 32'd30, 18, 9));
		r = idle_row(3'd4);
		{r.c0v, r.c0wb, r.c0n, r.c0d} = {2'b11, 6'd30, d[17]};
		r.exp_full = 1'b1;
		add_row(r);
		r = idle_row(3'd4);
		r.exp_full = 1'b1;
		add_row(r);
		repeat (5) add_row(idle_row(3'd4));
		for (int k = 6; k <= 9; k++) mark_issue(base + k);
		expect_op(6, d[17], d[14], 15, 6);
		expect_op(7, d[17], d[15], 16, 7);
		expect_op(8, d[16], d[17], 17, 8);
		expect_op(9, d[17], d[17], 18, 9);
		// Hold under exec_lock and flush
		base = n_rows;
		add_row(dispatch_row(3'd5, 10, 1'b1, d[18], 1'b1, d[19], 19, 10));
		add_row(dispatch_row(3'd5, 11, 1'b1, d[20], 1'b1, d[21], 20, 11));
		r = idle_row(3'd5);
		r.lock = 1'b1;
		repeat (2) add_row(r);
		repeat (3) add_row(idle_row(3'd5));
		add_row(dispatch_row(3'd5, 12, 1'b0, 32'd40, 1'b1, d[22], 21, 12));
		add_row(dispatch_row(3'd5, 13, 1'b1, d[23], 1'b1, d[24], 22, 13));
		r = idle_row(3'd5);
		r.rm = 1'b1;
		add_row(r);
		r = idle_row(3'd5);
		{r.c0v, r.c0wb, r.c0n, r.c0d} = {2'b11, 6'd40, d[25]};
		add_row(r);
		repeat (2) add_row(idle_row(3'd5));
		for (int k = 2; k <= 5; k++) mark_issue(base + k);
		expect_op(10, d[18], d[19], 19, 10);
		expect_op(11, d[20], d[21], 20, 11);
	endtask

	task automatic apply_row(input row_t r);
		register_valid = r.rv;
		{destination_sysreg, writeback, afe, sys_reg, logic_op, shift, adder} = r.flags;
		cmd = r.cmd;
		source0_valid = r.s0v;
		source0 = r.s0;
		source1_valid = r.s1v;
		source1 = r.s1;
		destination_regname = r.dest;
		commit_tag = r.tag;
		{cdb0_valid, cdb0_writeback, cdb0_regname, cdb0_data} = {r.c0v, r.c0wb, r.c0n, r.c0d};
		{cdb1_valid, cdb1_writeback, cdb1_regname, cdb1_data} = {r.c1v, r.c1wb, r.c1n, r.c1d};
		{cdb2_valid, cdb2_regname, cdb2_data} = {r.c2v, r.c2n, r.c2d};
		remove_valid = r.rm;
		exec_lock = r.lock;
		test_id = r.test;
		exp_full = r.exp_full;
		exp_issue = r.exp_issue;
	endtask

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Watchdog
	initial begin
		#((N_ROWS + 20) * 100);
		$display("Timeout: the run did not reach the end of the stimulus table");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		inRESET = 1'b0;
		checking = 1'b0;
		done = 1'b0;
		n_rows = 0;
		n_exp = 0;
		for (int i = 0; i < MAX_EXP; i++) exp_ops[i] = '0;
		apply_row(idle_row(3'd0));
		void'($urandom(32'hacf5));
		for (int i = 0; i < 26; i++) d[i] = $urandom();
		for (int i = 0; i < 16; i++) fl[i] = 10'($urandom());
		build_tables();
		repeat (2) @(negedge iCLOCK);
		inRESET = 1'b1;
		for (int k = 0; k < n_rows; k++) begin
			@(negedge iCLOCK);
			apply_row(rows[k]);
			checking = 1'b1;
		end
		@(negedge iCLOCK);
		apply_row(idle_row(3'd0));
		done = 1'b1;
		@(negedge iCLOCK);
		if (fail_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: rtl/alu2_rs_pkg.sv
package alu2_rs_pkg;

	// Station geometry
	localparam int RS_ENTRIES = 4;
	localparam int RS_IDX_W = 2;

	// Field widths
	localparam int REGNAME_W = 6;
	localparam int DATA_W = 32;
	localparam int CMD_W = 5;
	localparam int AFE_W = 4;
	localparam int TAG_W = 6;

	// Operand word, a value once valid, otherwise the awaited register name
	typedef union packed {
		logic [DATA_W-1:0] data;
		struct packed {
			logic [DATA_W-REGNAME_W-1:0] pad;
			logic [REGNAME_W-1:0] regname;
		} wait_reg;
	} rs_source_t;

endpackage

// File: rtl/reservation_alu2.sv
module reservation_alu2 (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove_valid,
	// Dispatch
	input logic register_valid,
	output logic full,
	input logic destination_sysreg,
	input logic writeback,
	input logic [alu2_rs_pkg::CMD_W-1:0] cmd,
	input logic [alu2_rs_pkg::AFE_W-1:0] afe,
	input logic sys_reg,
	input logic logic_op,
	input logic shift,
	input logic adder,
	input logic source0_valid,
	input alu2_rs_pkg::rs_source_t source0,
	input logic source1_valid,
	input alu2_rs_pkg::rs_source_t source1,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] destination_regname,
	input logic [alu2_rs_pkg::TAG_W-1:0] commit_tag,
	// CDB
	input logic cdb0_valid,
	input logic cdb0_writeback,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] cdb0_regname,
	input logic [alu2_rs_pkg::DATA_W-1:0] cdb0_data,
	input logic cdb1_valid,
	input logic cdb1_writeback,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] cdb1_regname,
	input logic [alu2_rs_pkg::DATA_W-1:0] cdb1_data,
	input logic cdb2_valid,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] cdb2_regname,
	input logic [alu2_rs_pkg::DATA_W-1:0] cdb2_data,
	// Execution unit
	input logic exec_lock,
	output logic issue_valid,
	output logic [alu2_rs_pkg::CMD_W-1:0] issue_cmd,
	output logic [alu2_rs_pkg::AFE_W-1:0] issue_afe,
	output logic issue_sys_reg,
	output logic issue_logic,
	output logic issue_shift,
	output logic issue_adder,
	output logic issue_writeback,
	output logic issue_destination_sysreg,
	output logic [alu2_rs_pkg::DATA_W-1:0] issue_source0,
	output logic [alu2_rs_pkg::DATA_W-1:0] issue_source1,
	output logic [alu2_rs_pkg::REGNAME_W-1:0] issue_destination_regname,
	output logic [alu2_rs_pkg::TAG_W-1:0] issue_commit_tag
);
	import alu2_rs_pkg::*;

	logic [RS_ENTRIES-1:0] entry_valid;
	logic [RS_ENTRIES-1:0] entry_matching;
	logic [RS_ENTRIES-1:0] entry_regist;
	logic [RS_ENTRIES-1:0] entry_issue;
	logic [RS_ENTRIES-1:0] entry_destination_sysreg;
	logic [RS_ENTRIES-1:0] entry_writeback;
	logic [RS_ENTRIES-1:0][CMD_W-1:0] entry_cmd;
	logic [RS_ENTRIES-1:0][AFE_W-1:0] entry_afe;
	logic [RS_ENTRIES-1:0] entry_sys_reg;
	logic [RS_ENTRIES-1:0] entry_logic;
	logic [RS_ENTRIES-1:0] entry_shift;
	logic [RS_ENTRIES-1:0] entry_adder;
	rs_source_t [RS_ENTRIES-1:0] entry_source0;
	rs_source_t [RS_ENTRIES-1:0] entry_source1;
	logic [RS_ENTRIES-1:0][REGNAME_W-1:0] entry_destination_regname;
	logic [RS_ENTRIES-1:0][TAG_W-1:0] entry_commit_tag;

	reservation_alu2_alloc u_alloc (
		.iCLOCK, .inRESET, .remove_valid, .register_valid,
		.entry_valid, .entry_issue, .entry_regist, .full
	);

	for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_entry
		reservation_alu2_entry u_entry (
			.iCLOCK, .inRESET, .remove_valid,
			.regist(entry_regist[i]),
			.issue(entry_issue[i]),
			.destination_sysreg, .writeback, .cmd, .afe,
			.sys_reg, .logic_op, .shift, .adder,
			.source0_valid, .source0, .source1_valid, .source1,
			.destination_regname, .commit_tag,
			.cdb0_valid, .cdb0_writeback, .cdb0_regname, .cdb0_data,
			.cdb1_valid, .cdb1_writeback, .cdb1_regname, .cdb1_data,
			.cdb2_valid, .cdb2_regname, .cdb2_data,
			.valid(entry_valid[i]),
			.matching(entry_matching[i]),
			.info_destination_sysreg(entry_destination_sysreg[i]),
			.info_writeback(entry_writeback[i]),
			.info_cmd(entry_cmd[i]),
			.info_afe(entry_afe[i]),
			.info_sys_reg(entry_sys_reg[i]),
			.info_logic(entry_logic[i]),
			.info_shift(entry_shift[i]),
			.info_adder(entry_adder[i]),
			.info_source0_valid(),
			.info_source0(entry_source0[i]),
			.info_source1_valid(),
			.info_source1(entry_source1[i]),
			.info_destination_regname(entry_destination_regname[i]),
			.info_commit_tag(entry_commit_tag[i])
		);
	end

	reservation_alu2_issue u_issue (
		.iCLOCK, .inRESET, .remove_valid, .exec_lock,
		.entry_matching, .entry_destination_sysreg, .entry_writeback,
		.entry_cmd, .entry_afe, .entry_sys_reg, .entry_logic,
		.entry_shift, .entry_adder, .entry_source0, .entry_source1,
		.entry_destination_regname, .entry_commit_tag,
		.entry_issue, .issue_valid,
		.issue_cmd, .issue_afe, .issue_sys_reg, .issue_logic,
		.issue_shift, .issue_adder, .issue_writeback, .issue_destination_sysreg,
		.issue_source0, .issue_source1,
		.issue_destination_regname, .issue_commit_tag
	);

endmodule

// File: rtl/reservation_alu2_alloc.sv
module reservation_alu2_alloc (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove_valid,
	input logic register_valid,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_valid,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_issue,
	output logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_regist,
	output logic full
);
	import alu2_rs_pkg::*;

	logic [RS_IDX_W:0] count;
	logic [RS_IDX_W-1:0] free_idx;
	logic free_found;
	logic accept;
	logic issued;

	// Lowest free entry
	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
			if (!entry_valid[i]) begin
				free_found = 1'b1;
				free_idx = RS_IDX_W'(i);
			end
		end
	end

	assign accept = register_valid && !full && free_found;
	assign issued = |entry_issue;
	assign entry_regist = accept ? (RS_ENTRIES'(1) << free_idx) : '0;
	assign full = (count == (RS_IDX_W + 1)'(RS_ENTRIES));

	// Occupancy count
	always_ff @(posedge iCLOCK) begin
		if (!inRESET) begin
			count <= '0;
		end else if (remove_valid) begin
			count <= '0;
		end else begin
			case ({accept, issued})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: rtl/reservation_alu2_entry.sv
module reservation_alu2_entry (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove_valid,
	input logic regist,
	input logic issue,
	// Dispatch
	input logic destination_sysreg,
	input logic writeback,
	input logic [alu2_rs_pkg::CMD_W-1:0] cmd,
	input logic [alu2_rs_pkg::AFE_W-1:0] afe,
	input logic sys_reg,
	input logic logic_op,
	input logic shift,
	input logic adder,
	input logic source0_valid,
	input alu2_rs_pkg::rs_source_t source0,
	input logic source1_valid,
	input alu2_rs_pkg::rs_source_t source1,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] destination_regname,
	input logic [alu2_rs_pkg::TAG_W-1:0] commit_tag,
	// CDB channel 0, adder
	input logic cdb0_valid,
	input logic cdb0_writeback,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] cdb0_regname,
	input logic [alu2_rs_pkg::DATA_W-1:0] cdb0_data,
	// CDB channel 1, muldiv
	input logic cdb1_valid,
	input logic cdb1_writeback,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] cdb1_regname,
	input logic [alu2_rs_pkg::DATA_W-1:0] cdb1_data,
	// CDB channel 2, load/store
	input logic cdb2_valid,
	input logic [alu2_rs_pkg::REGNAME_W-1:0] cdb2_regname,
	input logic [alu2_rs_pkg::DATA_W-1:0] cdb2_data,
	// Entry state
	output logic valid,
	output logic matching,
	output logic info_destination_sysreg,
	output logic info_writeback,
	output logic [alu2_rs_pkg::CMD_W-1:0] info_cmd,
	output logic [alu2_rs_pkg::AFE_W-1:0] info_afe,
	output logic info_sys_reg,
	output logic info_logic,
	output logic info_shift,
	output logic info_adder,
	output logic info_source0_valid,
	output alu2_rs_pkg::rs_source_t info_source0,
	output logic info_source1_valid,
	output alu2_rs_pkg::rs_source_t info_source1,
	output logic [alu2_rs_pkg::REGNAME_W-1:0] info_destination_regname,
	output logic [alu2_rs_pkg::TAG_W-1:0] info_commit_tag
);
	import alu2_rs_pkg::*;

	logic [DATA_W:0] src0_new;
	logic [DATA_W:0] src1_new;
	logic [DATA_W:0] src0_wake;
	logic [DATA_W:0] src1_wake;

	// Hit bit on top of the data, channel 0 has priority
	function automatic logic [DATA_W:0] cdb_lookup(input logic [REGNAME_W-1:0] name);
		logic [DATA_W:0] result;
		result = '0;
		if (cdb0_valid && cdb0_writeback && (cdb0_regname == name)) begin
			result = {1'b1, cdb0_data};
		end else if (cdb1_valid && cdb1_writeback && (cdb1_regname == name)) begin
			result = {1'b1, cdb1_data};
		end else if (cdb2_valid && (cdb2_regname == name)) begin
			result = {1'b1, cdb2_data};
		end
		return result;
	endfunction

	// Dispatch value first, then same-cycle forwarding
	function automatic logic [DATA_W:0] resolve_source(
		input logic word_valid,
		input rs_source_t word
	);
		logic [DATA_W:0] hit;
		logic [DATA_W:0] result;
		hit = cdb_lookup(word.wait_reg.regname);
		if (word_valid) begin
			result = {1'b1, word.data};
		end else if (hit[DATA_W]) begin
			result = hit;
		end else begin
			result = {1'b0, {(DATA_W-REGNAME_W){1'b0}}, word.wait_reg.regname};
		end
		return result;
	endfunction

	always_comb begin
		src0_new = resolve_source(source0_valid, source0);
		src1_new = resolve_source(source1_valid, source1);
		src0_wake = cdb_lookup(info_source0.wait_reg.regname);
		src1_wake = cdb_lookup(info_source1.wait_reg.regname);
	end

	always_ff @(posedge iCLOCK) begin
		if (!inRESET) begin
			valid <= 1'b0;
			info_source0_valid <= 1'b0;
			info_source1_valid <= 1'b0;
		end else if (remove_valid || issue) begin
			valid <= 1'b0;
			info_source0_valid <= 1'b0;
			info_source1_valid <= 1'b0;
		end else if (regist) begin
			valid <= 1'b1;
			info_destination_sysreg <= destination_sysreg;
			info_writeback <= writeback;
			info_cmd <= cmd;
			info_afe <= afe;
			info_sys_reg <= sys_reg;
			info_logic <= logic_op;
			info_shift <= shift;
			info_adder <= adder;
			info_destination_regname <= destination_regname;
			info_commit_tag <= commit_tag;
			{info_source0_valid, info_source0} <= src0_new;
			{info_source1_valid, info_source1} <= src1_new;
		end else if (valid) begin
			// Wakeup of waiting operands
			if (!info_source0_valid && src0_wake[DATA_W]) begin
				{info_source0_valid, info_source0} <= src0_wake;
			end
			if (!info_source1_valid && src1_wake[DATA_W]) begin
				{info_source1_valid, info_source1} <= src1_wake;
			end
		end
	end

	assign matching = valid && info_source0_valid && info_source1_valid;

endmodule

// File: rtl/reservation_alu2_issue.sv
module reservation_alu2_issue (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove_valid,
	input logic exec_lock,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_matching,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_destination_sysreg,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_writeback,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0][alu2_rs_pkg::CMD_W-1:0] entry_cmd,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0][alu2_rs_pkg::AFE_W-1:0] entry_afe,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_sys_reg,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_logic,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_shift,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_adder,
	input alu2_rs_pkg::rs_source_t [alu2_rs_pkg::RS_ENTRIES-1:0] entry_source0,
	input alu2_rs_pkg::rs_source_t [alu2_rs_pkg::RS_ENTRIES-1:0] entry_source1,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0][alu2_rs_pkg::REGNAME_W-1:0]
		entry_destination_regname,
	input logic [alu2_rs_pkg::RS_ENTRIES-1:0][alu2_rs_pkg::TAG_W-1:0] entry_commit_tag,
	output logic [alu2_rs_pkg::RS_ENTRIES-1:0] entry_issue,
	output logic issue_valid,
	output logic [alu2_rs_pkg::CMD_W-1:0] issue_cmd,
	output logic [alu2_rs_pkg::AFE_W-1:0] issue_afe,
	output logic issue_sys_reg,
	output logic issue_logic,
	output logic issue_shift,
	output logic issue_adder,
	output logic issue_writeback,
	output logic issue_destination_sysreg,
	output logic [alu2_rs_pkg::DATA_W-1:0] issue_source0,
	output logic [alu2_rs_pkg::DATA_W-1:0] issue_source1,
	output logic [alu2_rs_pkg::REGNAME_W-1:0] issue_destination_regname,
	output logic [alu2_rs_pkg::TAG_W-1:0] issue_commit_tag
);
	import alu2_rs_pkg::*;

	logic pick_found;
	logic [RS_IDX_W-1:0] pick_idx;
	logic pick_take;

	// Lowest ready entry
	always_comb begin
		pick_found = 1'b0;
		pick_idx = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
			if (entry_matching[i]) begin
				pick_found = 1'b1;
				pick_idx = RS_IDX_W'(i);
			end
		end
	end

	// Issue register free or draining this cycle
	assign pick_take = pick_found && !exec_lock && !remove_valid;
	assign entry_issue = pick_take ? (RS_ENTRIES'(1) << pick_idx) : '0;

	always_ff @(posedge iCLOCK) begin
		if (!inRESET) begin
			issue_valid <= 1'b0;
		end else if (remove_valid) begin
			issue_valid <= 1'b0;
		end else if (!exec_lock) begin
			issue_valid <= pick_take;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (pick_take) begin
			issue_cmd <= entry_cmd[pick_idx];
			issue_afe <= entry_afe[pick_idx];
			issue_sys_reg <= entry_sys_reg[pick_idx];
			issue_logic <= entry_logic[pick_idx];
			issue_shift <= entry_shift[pick_idx];
			issue_adder <= entry_adder[pick_idx];
			issue_writeback <= entry_writeback[pick_idx];
			issue_destination_sysreg <= entry_destination_sysreg[pick_idx];
			issue_source0 <= entry_source0[pick_idx].data;
			issue_source1 <= entry_source1[pick_idx].data;
			issue_destination_regname <= entry_destination_regname[pick_idx];
			issue_commit_tag <= entry_commit_tag[pick_idx];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
	--top-module tb_reservation_alu2 -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation error"; exit 1; }
grep -q "=== PASS ===" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: verilog.f
rtl/alu2_rs_pkg.sv
rtl/reservation_alu2_entry.sv
rtl/reservation_alu2_alloc.sv
rtl/reservation_alu2_issue.sv
rtl/reservation_alu2.sv
bench/rs_checker.sv
bench/tb_reservation_alu2.sv
